// ==== Makefile ====
TOP = pipelineTb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

run: build
	./obj_dir/V$(TOP) > run.log 2>&1 || true
	@cat run.log
	@! grep -qF "*** TEST FAILED ***" run.log
	@grep -qF "*** TEST PASSED ***" run.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir run.log

.PHONY: all build run lint clean

// ==== controlDecoder.sv ====
`include "pipeline_defines.svh"

module controlDecoder import pipelinePkg::*; (
    input  logic [`DATA_WIDTH-1:0]       instr,
    output ctrl_t                        ctrl,
    output logic [`REG_ADDR_WIDTH-1:0]   rsNum,
    output logic [`REG_ADDR_WIDTH-1:0]   rtNum,
    output logic [`REG_ADDR_WIDTH-1:0]   writeReg,
    output logic [`DATA_WIDTH-1:0]       immExt,
    output logic [`JUMP_INDEX_WIDTH-1:0] jumpIndex
);

    opcode_e                    opcode;
    funct_e                     funct;
    logic [`REG_ADDR_WIDTH-1:0] rs, rt, rd;
    logic [`REG_ADDR_WIDTH-1:0] dest;
    ctrl_t                      raw;

    assign opcode    = opcode_e'(instr[31:26]);
    assign funct     = funct_e'(instr[5:0]);
    assign rs        = instr[25:21];
    assign rt        = instr[20:16];
    assign rd        = instr[15:11];
    assign immExt    = {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]};
    assign jumpIndex = instr[`JUMP_INDEX_WIDTH-1:0];

    always_comb begin
        raw   = '0;         // anything unknown falls through as a no-op
        dest  = '0;
        rsNum = rs;
        rtNum = rt;
        case (opcode)
            OP_RTYPE: begin
                dest = rd;
                case (funct)
                    FN_ADD: begin raw.regWrite = 1'b1; raw.aluOp = ALU_ADD; end
                    FN_SUB: begin raw.regWrite = 1'b1; raw.aluOp = ALU_SUB; end
                    FN_AND: begin raw.regWrite = 1'b1; raw.aluOp = ALU_AND; end
                    FN_OR:  begin raw.regWrite = 1'b1; raw.aluOp = ALU_OR;  end
                    FN_SLT: begin raw.regWrite = 1'b1; raw.aluOp = ALU_SLT; end
                    FN_SYSCALL: begin
                        raw.syscall = 1'b1;
                        rsNum       = `REG_V0;   // service code rides operand A
                        rtNum       = `REG_A0;   // argument rides operand B
                    end
                    default: ;
                endcase
            end
            OP_ADDI, OP_LW: begin
                raw.regWrite  = 1'b1;
                raw.memToReg  = (opcode == OP_LW);
                raw.aluSrcImm = 1'b1;
                dest          = rt;
                rtNum         = '0;          // rt is the target, not a source
            end
            OP_SW: begin
                raw.memWrite  = 1'b1;
                raw.aluSrcImm = 1'b1;
            end
            OP_BEQ: raw.branchEq = 1'b1;
            OP_BNE: raw.branchNe = 1'b1;
            OP_J: begin
                raw.jump = 1'b1;
                rsNum    = '0;               // index bits, no sources
                rtNum    = '0;
            end
            default: ;
        endcase
    end

    // r0 is never a real destination
    always_comb begin
        ctrl          = raw;
        ctrl.regWrite = raw.regWrite && (dest != '0);
    end

    assign writeReg = dest;

    aluOpDefined: assert final (!ctrl.regWrite ||
        ctrl.aluOp inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT});

endmodule

// ==== dataMemory.sv ====
`include "pipeline_defines.svh"

module dataMemory (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`DMEM_ADDR_WIDTH-1:0] addr,         // word index
    input  logic [1:0]                  byteOffset,   // low address bits, checked only
    input  logic                        rdEn,
    input  logic                        wrEn,
    input  logic [`DATA_WIDTH-1:0]      wrData,
    output logic [`DATA_WIDTH-1:0]      rdData
);

    logic [`DATA_WIDTH-1:0] mem [`DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

    assign rdData = rdEn ? mem[addr] : '0;   // async read

    // word accesses only, lw/sw with a byte offset are not supported
    wordAligned: assert property (@(posedge clk) disable iff (rst)
        (rdEn || wrEn) |-> (byteOffset == 2'b00));

endmodule

// ==== executeStage.sv ====
`include "pipeline_defines.svh"

module executeStage import pipelinePkg::*; (
    input  idEx_t                  idEx,
    input  logic [1:0]             fwdSelA,
    input  logic [1:0]             fwdSelB,
    input  logic [`DATA_WIDTH-1:0] memFwdData,
    input  logic [`DATA_WIDTH-1:0] wbFwdData,
    output logic [`DATA_WIDTH-1:0] aluResult,
    output logic [`DATA_WIDTH-1:0] storeData,
    output logic                   branchTaken,
    output logic [`DATA_WIDTH-1:0] branchTarget
);

    function automatic logic [`DATA_WIDTH-1:0] fwdMux(input logic [1:0] sel,
                                                      input logic [`DATA_WIDTH-1:0] regVal,
                                                      input logic [`DATA_WIDTH-1:0] memVal,
                                                      input logic [`DATA_WIDTH-1:0] wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    logic [`DATA_WIDTH-1:0] opA, opB, aluB;
    logic [`DATA_WIDTH-1:0] aluOut;
    logic [`DATA_WIDTH-1:0] pcPlus4;
    logic                   equal;

    assign opA  = fwdMux(fwdSelA, idEx.rsVal, memFwdData, wbFwdData);
    assign opB  = fwdMux(fwdSelB, idEx.rtVal, memFwdData, wbFwdData);
    assign aluB = idEx.ctrl.aluSrcImm ? idEx.immExt : opB;   // addi, lw, sw

    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_ADD: aluOut = opA + aluB;
            ALU_SUB: aluOut = opA - aluB;
            ALU_AND: aluOut = opA & aluB;
            ALU_OR:  aluOut = opA | aluB;
            ALU_SLT: aluOut = {{(`DATA_WIDTH-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default: aluOut = '0;
        endcase
    end

    assign aluResult = idEx.ctrl.syscall ? opA : aluOut;   // syscall carries v0
    assign storeData = opB;                                // store data or a0

    assign equal       = (opA == opB);
    assign branchTaken = idEx.ctrl.jump
                       || (idEx.ctrl.branchEq && equal)
                       || (idEx.ctrl.branchNe && !equal);

    assign pcPlus4 = idEx.pc + `DATA_WIDTH'(4);

    always_comb begin
        if (idEx.ctrl.jump) begin
            branchTarget = {pcPlus4[`DATA_WIDTH-1 -: 4], idEx.jumpIndex, 2'b00};
        end else begin
            branchTarget = pcPlus4 + {idEx.immExt[`DATA_WIDTH-3:0], 2'b00};
        end
    end

endmodule

// ==== hazardUnit.sv ====
`include "pipeline_defines.svh"

module hazardUnit import pipelinePkg::*; (
    input  idEx_t      idEx,
    input  exMem_t     exMem,
    input  memWb_t     memWb,
    output logic [1:0] fwdSelA,
    output logic [1:0] fwdSelB,
    output logic       loadUseStall
);

    // nearest producer wins, loads in memory stage are left to the stall
    function automatic logic [1:0] pickSource(input logic [`REG_ADDR_WIDTH-1:0] src,
                                              input exMem_t mem,
                                              input memWb_t wb);
        logic [1:0] sel;
        sel = FWD_REG;
        if (src != '0) begin
            if (mem.ctrl.regWrite && !mem.ctrl.memToReg && mem.writeReg == src) begin
                sel = FWD_MEM;
            end else if (wb.ctrl.regWrite && wb.writeReg == src) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    logic loadInMem;
    logic hitA, hitB;

    assign fwdSelA = pickSource(idEx.rsNum, exMem, memWb);
    assign fwdSelB = pickSource(idEx.rtNum, exMem, memWb);

    assign loadInMem = exMem.ctrl.regWrite && exMem.ctrl.memToReg;
    assign hitA      = (idEx.rsNum != '0) && (idEx.rsNum == exMem.writeReg);
    assign hitB      = (idEx.rtNum != '0) && (idEx.rtNum == exMem.writeReg);

    assign loadUseStall = loadInMem && (hitA || hitB);   // one bubble, then wb forward

    noMemFwdOfLoad: assert final (!exMem.ctrl.memToReg ||
        (fwdSelA != FWD_MEM && fwdSelB != FWD_MEM));

endmodule

// ==== pipelineChecker.sv ====
`include "pipeline_defines.svh"

module pipelineChecker import pipelinePkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       progReady,
    input  logic [`DATA_WIDTH-1:0]     imem [2**`IMEM_ADDR_WIDTH],
    input  logic                       wbValid,
    input  logic [`REG_ADDR_WIDTH-1:0] wbReg,
    input  logic [`DATA_WIDTH-1:0]     wbData,
    input  logic [`DATA_WIDTH-1:0]     dispValue,
    input  logic                       halted,
    output int                         errorCount,
    output int                         writesSeen,
    output int                         writesExpected,
    output int                         haltRises
);

    localparam int IMEM_WORDS  = 2**`IMEM_ADDR_WIDTH;
    localparam int HALT_POINTS = 2;               // middle and final syscall
    localparam int MAX_STEPS   = 4 * IMEM_WORDS;

    logic [`REG_ADDR_WIDTH-1:0] expReg [$];
    logic [`DATA_WIDTH-1:0]     expData [$];
    logic [`DATA_WIDTH-1:0]     expDisp [$];
    int                         dispAtWrite [$];  // writes issued before each display
    int                         haltAtWrite [$];  // writes issued before each halt
    int                         dispSeen;
    logic [`DATA_WIDTH-1:0]     lastDisp;
    logic                       lastHalted;

    ////////////////////////////////////////////////////////////
    // instruction-level model of the program
    ////////////////////////////////////////////////////////////

    task automatic runModel();
        logic [`DATA_WIDTH-1:0]     r [32];
        logic [`DATA_WIDTH-1:0]     dm [`DMEM_WORDS];
        logic [`DATA_WIDTH-1:0]     ins, a, b, imm, res, addr;
        logic [`REG_ADDR_WIDTH-1:0] dst;
        logic                       wr;
        int                         idx;
        int                         steps;
        logic                       done;
        for (int k = 0; k < 32; k++) begin
            r[k]  = '0;
            dm[k] = '0;
        end
        idx   = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < MAX_STEPS && idx < IMEM_WORDS) begin
            ins  = imem[idx];
            a    = r[ins[25:21]];
            b    = r[ins[20:16]];
            imm  = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            dst  = ins[20:16];
            res  = '0;
            wr   = 1'b0;
            idx  = idx + 1;
            case (ins[31:26])
                OP_RTYPE: begin
                    dst = ins[15:11];
                    wr  = 1'b1;
                    case (ins[5:0])
                        FN_ADD: res = a + b;
                        FN_SUB: res = a - b;
                        FN_AND: res = a & b;
                        FN_OR:  res = a | b;
                        FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SYSCALL: begin
                            wr = 1'b0;
                            if (r[`REG_V0] == `SYSCALL_DISPLAY) begin
                                expDisp.push_back(r[`REG_A0]);
                                dispAtWrite.push_back(expReg.size());
                            end else begin
                                haltAtWrite.push_back(expReg.size());
                                done = (haltAtWrite.size() == HALT_POINTS);
                            end
                        end
                        default: wr = 1'b0;   // unknown funct is a no-op
                    endcase
                end
                OP_ADDI: begin
                    wr  = 1'b1;
                    res = a + imm;
                end
                OP_LW: begin
                    wr  = 1'b1;
                    res = dm[addr[`DMEM_ADDR_WIDTH+1:2]];
                end
                OP_SW:  dm[addr[`DMEM_ADDR_WIDTH+1:2]] = b;
                OP_BEQ: if (a == b) idx = idx + int'($signed(imm));
                OP_BNE: if (a != b) idx = idx + int'($signed(imm));
                OP_J:   idx = int'(ins[25:0]);
                default: ;
            endcase
            if (wr && dst != '0) begin
                r[dst] = res;
                expReg.push_back(dst);
                expData.push_back(res);
            end
            steps++;
        end
        writesExpected = expReg.size();
    endtask

    initial begin
        writesExpected = 0;
        wait (progReady);
        runModel();
    end

    ////////////////////////////////////////////////////////////
    // stream comparison at mid-cycle
    ////////////////////////////////////////////////////////////

    task automatic checkDisplay();
        if (dispValue != lastDisp) begin
            if (dispSeen >= expDisp.size()) begin
                $display("display changed although the model runs no further display syscall");
                errorCount++;
            end else begin
                if (dispValue != expDisp[dispSeen]) begin
                    $display("FAILED dispValue: got %h expected %h", dispValue, expDisp[dispSeen]);
                    errorCount++;
                end
                if (writesSeen != dispAtWrite[dispSeen]) begin
                    $display("display updated after %0d writes, the model shows it after %0d",
                             writesSeen, dispAtWrite[dispSeen]);
                    errorCount++;
                end
            end
            dispSeen++;
            lastDisp = dispValue;
        end
    endtask

    task automatic checkWrite();
        if (wbValid) begin
            if (halted) begin
                $display("a register write appeared while the core was halted");
                errorCount++;
            end
            if (wbReg == '0) begin
                $display("a write to register 0 was reported");
                errorCount++;
            end else if (writesSeen >= expReg.size()) begin
                $display("the core wrote more registers than the model issues");
                errorCount++;
            end else begin
                if (wbReg != expReg[writesSeen]) begin
                    $display("FAILED wbReg: got %h expected %h", wbReg, expReg[writesSeen]);
                    errorCount++;
                end
                if (wbData != expData[writesSeen]) begin
                    $display("FAILED wbData: got %h expected %h", wbData, expData[writesSeen]);
                    errorCount++;
                end
            end
            writesSeen++;
        end
    endtask

    task automatic checkHalt();
        if (halted && !lastHalted) begin
            haltRises++;
            if (haltRises > haltAtWrite.size()) begin
                $display("halted rose with no halting syscall left in the model");
                errorCount++;
            end else if (writesSeen != haltAtWrite[haltRises-1]) begin
                $display("halt %0d came after %0d writes, the model expects %0d",
                         haltRises, writesSeen, haltAtWrite[haltRises-1]);
                errorCount++;
            end
            if (haltRises == HALT_POINTS) begin
                if (dispSeen != expDisp.size()) begin
                    $display("only %0d of %0d display updates were seen",
                             dispSeen, expDisp.size());
                    errorCount++;
                end
                if (writesSeen != writesExpected) begin
                    $display("write count mismatch: %0d seen, %0d from the model",
                             writesSeen, writesExpected);
                    errorCount++;
                end
            end
        end
        lastHalted = halted;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            errorCount = 0;
            writesSeen = 0;
            haltRises  = 0;
            dispSeen   = 0;
            lastDisp   = '0;
            lastHalted = 1'b0;
        end else begin
            checkDisplay();   // before the write of the instruction behind the syscall
            checkWrite();
            checkHalt();
        end
    end

endmodule

// ==== pipelineCore.sv ====
`include "pipeline_defines.svh"

module pipelineCore import pipelinePkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    output logic [`IMEM_ADDR_WIDTH-1:0] imemAddr,
    input  logic [`DATA_WIDTH-1:0]      imemData,
    input  logic                        go,
    output logic                        wbValid,
    output logic [`REG_ADDR_WIDTH-1:0]  wbReg,
    output logic [`DATA_WIDTH-1:0]      wbData,
    output logic [`DATA_WIDTH-1:0]      dispValue,
    output logic                        halted
);

    logic [`DATA_WIDTH-1:0] pc;
    ifId_t                  ifId;
    idEx_t                  idEx, idExNext, idExHold;
    exMem_t                 exMem, exMemNext;
    memWb_t                 memWb, memWbNext;

    ctrl_t                        decCtrl;
    logic [`REG_ADDR_WIDTH-1:0]   decRsNum, decRtNum, decWriteReg;
    logic [`DATA_WIDTH-1:0]       decImmExt;
    logic [`JUMP_INDEX_WIDTH-1:0] decJumpIndex;
    logic [`DATA_WIDTH-1:0]       rsVal, rtVal;

    logic [1:0]             fwdSelA, fwdSelB;
    logic                   loadUseStall;
    logic [`DATA_WIDTH-1:0] aluResult, storeData, branchTarget;
    logic                   branchTaken;
    logic [`DATA_WIDTH-1:0] loadData;
    logic                   displayHit;

    ////////////////////////////////////////////////////////////
    // fetch and decode
    ////////////////////////////////////////////////////////////

    assign imemAddr = pc[`IMEM_ADDR_WIDTH+1:2];

    controlDecoder u_decoder (
        .instr(ifId.instr), .ctrl(decCtrl), .rsNum(decRsNum), .rtNum(decRtNum),
        .writeReg(decWriteReg), .immExt(decImmExt), .jumpIndex(decJumpIndex)
    );

    regFile u_regFile (
        .clk(clk), .rst(rst), .rdNumA(decRsNum), .rdNumB(decRtNum),
        .wrNum(memWb.writeReg), .wrEn(memWb.ctrl.regWrite), .wrData(wbData),
        .rdDataA(rsVal), .rdDataB(rtVal)
    );

    assign idExNext = '{ctrl: decCtrl, pc: ifId.pc, rsNum: decRsNum, rtNum: decRtNum,
                        rsVal: rsVal, rtVal: rtVal, immExt: decImmExt,
                        jumpIndex: decJumpIndex, writeReg: decWriteReg};

    ////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////

    hazardUnit u_hazard (
        .idEx(idEx), .exMem(exMem), .memWb(memWb),
        .fwdSelA(fwdSelA), .fwdSelB(fwdSelB), .loadUseStall(loadUseStall)
    );

    executeStage u_execute (
        .idEx(idEx), .fwdSelA(fwdSelA), .fwdSelB(fwdSelB),
        .memFwdData(exMem.aluResult), .wbFwdData(wbData),
        .aluResult(aluResult), .storeData(storeData),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    assign exMemNext = '{ctrl: idEx.ctrl, aluResult: aluResult, storeData: storeData,
                         writeReg: idEx.writeReg};

    // the writeback value leaves the register file during a stall, so keep it
    always_comb begin
        idExHold = idEx;
        if (memWb.ctrl.regWrite && memWb.writeReg == idEx.rsNum) begin
            idExHold.rsVal = wbData;
        end
        if (memWb.ctrl.regWrite && memWb.writeReg == idEx.rtNum) begin
            idExHold.rtVal = wbData;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory and writeback
    ////////////////////////////////////////////////////////////

    dataMemory u_dmem (
        .clk(clk), .rst(rst),
        .addr(exMem.aluResult[`DMEM_ADDR_WIDTH+1:2]),
        .byteOffset(exMem.aluResult[1:0]),
        .rdEn(exMem.ctrl.memToReg),
        .wrEn(exMem.ctrl.memWrite && !halted),   // no repeat stores while frozen
        .wrData(exMem.storeData), .rdData(loadData)
    );

    assign memWbNext = '{ctrl: exMem.ctrl, aluResult: exMem.aluResult, loadData: loadData,
                         storeData: exMem.storeData, writeReg: exMem.writeReg};

    assign wbData  = memWb.ctrl.memToReg ? memWb.loadData : memWb.aluResult;
    assign wbReg   = memWb.writeReg;
    assign wbValid = memWb.ctrl.regWrite;   // a halting syscall never writes

    assign displayHit = memWb.ctrl.syscall && (memWb.aluResult == `SYSCALL_DISPLAY);
    assign halted     = memWb.ctrl.syscall && (memWb.aluResult != `SYSCALL_DISPLAY) && !go;

    ////////////////////////////////////////////////////////////
    // pipeline advance with halt over load-use over redirect
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            ifId      <= '0;
            idEx      <= '0;
            exMem     <= '0;
            memWb     <= '0;
            dispValue <= '0;
        end else if (!halted) begin
            memWb <= memWbNext;
            if (loadUseStall) begin
                exMem <= '0;          // bubble behind the load
                idEx  <= idExHold;    // pc and if/id simply hold
            end else if (branchTaken) begin
                exMem <= exMemNext;
                idEx  <= '0;          // squash the two younger ones
                ifId  <= '0;
                pc    <= branchTarget;
            end else begin
                exMem <= exMemNext;
                idEx  <= idExNext;
                ifId  <= '{pc: pc, instr: imemData};
                pc    <= pc + `DATA_WIDTH'(4);
            end
            if (displayHit) begin
                dispValue <= memWb.storeData;
            end
        end
    end

endmodule

// ==== pipelinePkg.sv ====
`include "pipeline_defines.svh"

package pipelinePkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDI  = 6'd8,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SYSCALL = 6'd12,
        FN_ADD     = 6'd32,
        FN_SUB     = 6'd34,
        FN_AND     = 6'd36,
        FN_OR      = 6'd37,
        FN_SLT     = 6'd42
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOp_e;

    // operand source selects, shared by hazard detection and execute
    localparam logic [1:0] FWD_REG = 2'd0;
    localparam logic [1:0] FWD_WB  = 2'd1;
    localparam logic [1:0] FWD_MEM = 2'd2;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;   // also marks a load
        logic   memWrite;
        logic   aluSrcImm;
        logic   branchEq;
        logic   branchNe;
        logic   jump;
        logic   syscall;
        aluOp_e aluOp;
    } ctrl_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] instr;
    } ifId_t;

    typedef struct packed {
        ctrl_t                        ctrl;
        logic [`DATA_WIDTH-1:0]       pc;
        logic [`REG_ADDR_WIDTH-1:0]   rsNum;
        logic [`REG_ADDR_WIDTH-1:0]   rtNum;
        logic [`DATA_WIDTH-1:0]       rsVal;
        logic [`DATA_WIDTH-1:0]       rtVal;
        logic [`DATA_WIDTH-1:0]       immExt;
        logic [`JUMP_INDEX_WIDTH-1:0] jumpIndex;
        logic [`REG_ADDR_WIDTH-1:0]   writeReg;
    } idEx_t;

    typedef struct packed {
        ctrl_t                      ctrl;
        logic [`DATA_WIDTH-1:0]     aluResult;  // v0 for a syscall
        logic [`DATA_WIDTH-1:0]     storeData;  // a0 for a syscall
        logic [`REG_ADDR_WIDTH-1:0] writeReg;
    } exMem_t;

    typedef struct packed {
        ctrl_t                      ctrl;
        logic [`DATA_WIDTH-1:0]     aluResult;
        logic [`DATA_WIDTH-1:0]     loadData;
        logic [`DATA_WIDTH-1:0]     storeData;
        logic [`REG_ADDR_WIDTH-1:0] writeReg;
    } memWb_t;

endpackage

// ==== pipelineTb.sv ====
`include "pipeline_defines.svh"

module pipelineTb import pipelinePkg::*; ();

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 8;
    localparam int          DRIVE_DELAY  = 5;
    localparam int          PROG_LEN     = 200;
    localparam int          IMEM_WORDS   = 2**`IMEM_ADDR_WIDTH;
    localparam int          DISP_AT      = 66;              // addi v0, addi a0, syscall
    localparam int          HALT_AT      = 100;             // addi v0, syscall
    localparam int          FINAL_AT     = PROG_LEN - 2;
    localparam int          HALT_CODE    = 10;
    localparam int          GO_DELAY     = 20;
    localparam int          HALT_POINTS  = 2;
    localparam logic [15:0] SEED         = 16'd89;

    logic                        clk, rst, go, progReady;
    logic [`IMEM_ADDR_WIDTH-1:0] imemAddr;
    logic [`DATA_WIDTH-1:0]      imemData;
    logic                        wbValid, halted;
    logic [`REG_ADDR_WIDTH-1:0]  wbReg;
    logic [`DATA_WIDTH-1:0]      wbData, dispValue;
    logic [`DATA_WIDTH-1:0]      imem [IMEM_WORDS];
    logic [15:0]                 lfsrState;
    int                          errorCount, writesSeen, writesExpected, haltRises;

    assign imemData = imem[imemAddr];   // async fetch port

    pipelineCore u_dut (
        .clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData), .go(go),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .dispValue(dispValue), .halted(halted)
    );

    pipelineChecker u_checker (
        .clk(clk), .rst(rst), .progReady(progReady), .imem(imem),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .dispValue(dispValue), .halted(halted),
        .errorCount(errorCount), .writesSeen(writesSeen),
        .writesExpected(writesExpected), .haltRises(haltRises)
    );

    ////////////////////////////////////////////////////////////
    // random source and instruction encoding
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // maximal length taps
    endfunction

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v         = {v[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    function automatic logic [4:0] pickReg();
        return 5'(1 + randomBits(3) % 7);   // r1..r7
    endfunction

    function automatic logic [4:0] pickDest();
        return 5'(randomBits(3));   // r0 included so some writes get dropped
    endfunction

    function automatic logic [5:0] pickFunct();
        case (randomBits(3) % 5)
            0: return FN_ADD;
            1: return FN_SUB;
            2: return FN_AND;
            3: return FN_OR;
            default: return FN_SLT;
        endcase
    endfunction

    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [5:0] fn);
        return {6'd0, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic isReserved(input int i);
        return (i >= DISP_AT && i <= DISP_AT + 2) || (i >= HALT_AT && i <= HALT_AT + 1)
            || (i >= FINAL_AT);
    endfunction

    function automatic logic skipsReserved(input int i, input int skip);
        for (int k = 1; k <= skip; k++) begin
            if (isReserved(i + k)) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] randomInstr(input int i);
        logic [3:0] kind;
        logic [4:0] rs, rt, rd;
        int         skip;
        kind = 4'(randomBits(4));
        rs   = pickReg();
        rt   = pickReg();
        rd   = pickDest();
        skip = 1 + int'(randomBits(2) % 3);
        if (kind >= 13 && skipsReserved(i, skip)) kind = 4'd0;   // syscall blocks stay reachable
        if (kind <= 5) return encodeR(rs, rt, rd, pickFunct());
        if (kind <= 8) return encodeI(OP_ADDI, rs, rt, 16'(randomBits(16)));
        if (kind <= 10) return encodeI(OP_LW, 5'd0, rt, 16'(randomBits(5) * 4));
        if (kind <= 12) return encodeI(OP_SW, 5'd0, rt, 16'(randomBits(5) * 4));
        if (kind == 13) return encodeI(OP_BEQ, rs, rt, 16'(skip));
        if (kind == 14) return encodeI(OP_BNE, rs, rt, 16'(skip));
        return {OP_J, 26'(i + 1 + skip)};
    endfunction

    task automatic buildProgram();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < PROG_LEN && !isReserved(i)) ? randomInstr(i) : '0;
        end
        imem[DISP_AT]     = encodeI(OP_ADDI, 5'd0, `REG_V0, 16'(`SYSCALL_DISPLAY));
        imem[DISP_AT + 1] = encodeI(OP_ADDI, 5'd0, `REG_A0, {1'b0, 14'(randomBits(14)), 1'b1});
        imem[DISP_AT + 2] = encodeR(5'd0, 5'd0, 5'd0, FN_SYSCALL);
        imem[HALT_AT]     = encodeI(OP_ADDI, 5'd0, `REG_V0, 16'(HALT_CODE));
        imem[HALT_AT + 1] = encodeR(5'd0, 5'd0, 5'd0, FN_SYSCALL);
        imem[FINAL_AT]    = encodeI(OP_ADDI, 5'd0, `REG_V0, 16'(HALT_CODE));
        imem[FINAL_AT + 1] = encodeR(5'd0, 5'd0, 5'd0, FN_SYSCALL);
    endtask

    ////////////////////////////////////////////////////////////
    // clock, run control and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst       = 1'b1;
        go        = 1'b0;
        progReady = 1'b0;
        lfsrState = SEED;
        buildProgram();
        progReady = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst = 1'b0;
        wait (halted);                       // middle syscall reached writeback
        repeat (GO_DELAY) @(posedge clk);
        #DRIVE_DELAY go = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY go = 1'b0;
        wait (haltRises == HALT_POINTS);
        repeat (10) @(posedge clk);          // nothing may be written while halted
        #DRIVE_DELAY;
        $display("summary: %0d errors, %0d of %0d writes, %0d halts",
                 errorCount, writesSeen, writesExpected, haltRises);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #((10 * PROG_LEN + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the final syscall halted the core");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== pipeline_defines.svh ====
`ifndef PIPELINE_DEFINES_SVH
`define PIPELINE_DEFINES_SVH

// datapath widths
`define DATA_WIDTH        32
`define REG_ADDR_WIDTH    5
`define JUMP_INDEX_WIDTH  26     // J-type instr_index field

// data memory, word addressed
`define DMEM_WORDS        32
`define DMEM_ADDR_WIDTH   5

// instruction memory index width seen on imemAddr
`define IMEM_ADDR_WIDTH   8

// syscall service codes and argument registers
`define SYSCALL_DISPLAY   34     // v0 value that shows a0
`define REG_V0            5'd2
`define REG_A0            5'd4

`endif

// ==== regFile.sv ====
`include "pipeline_defines.svh"

module regFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`REG_ADDR_WIDTH-1:0] rdNumA,
    input  logic [`REG_ADDR_WIDTH-1:0] rdNumB,
    input  logic [`REG_ADDR_WIDTH-1:0] wrNum,
    input  logic                       wrEn,
    input  logic [`DATA_WIDTH-1:0]     wrData,
    output logic [`DATA_WIDTH-1:0]     rdDataA,
    output logic [`DATA_WIDTH-1:0]     rdDataB
);

    logic [`DATA_WIDTH-1:0] regs [2**`REG_ADDR_WIDTH];
    logic                   wrLive;

    assign wrLive = wrEn && (wrNum != '0);   // r0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrNum] <= wrData;
        end
    end

    // write-before-read, decode sees the value written back this cycle
    assign rdDataA = (wrLive && wrNum == rdNumA) ? wrData : regs[rdNumA];
    assign rdDataB = (wrLive && wrNum == rdNumB) ? wrData : regs[rdNumB];

    zeroRegA: assert property (@(posedge clk) disable iff (rst)
        (rdNumA == '0) |-> (rdDataA == '0));
    zeroRegB: assert property (@(posedge clk) disable iff (rst)
        (rdNumB == '0) |-> (rdDataB == '0));

endmodule

// ==== tb.f ====
+incdir+.
pipelinePkg.sv
controlDecoder.sv
regFile.sv
hazardUnit.sv
executeStage.sv
dataMemory.sv
pipelineCore.sv
pipelineChecker.sv
pipelineTb.sv
